// ==== all.f ====
src/afifo_pkg.sv
src/gray_ptr.sv
src/dual_clock_ram.sv
src/afifo_wr_stage.sv
src/afifo_rd_stage.sv
src/afifo_bridge.sv
bench/afifo_bridge_tb.sv

// ==== bench/afifo_bridge_tb.sv ====
`timescale 1ns/1ps

module afifo_bridge_tb
   import afifo_pkg::*;
();

   localparam int N_RANDOM = 400;
   // the read stage keeps two words outside the memory once it is primed
   localparam int N_FILL = DEPTH + 2;
   localparam int N_TOTAL = N_FILL + N_RANDOM;
   localparam int MAX_CYCLES = 20 * N_TOTAL + 200;
   // wclk cycles allowed for the final drain
   localparam int DRAIN_CYCLES = 8 * N_FILL;

   // source modes
   localparam int SRC_IDLE = 0;
   localparam int SRC_FILL = 1;
   localparam int SRC_RANDOM = 2;

   // sink modes
   localparam int SNK_LOW = 0;
   localparam int SNK_RANDOM = 1;
   localparam int SNK_HIGH = 2;

   logic             wclk;
   logic             rclk;
   logic             rst;
   logic             in_valid;
   fifo_word_t       in_word;
   logic             in_ready;
   logic             out_valid;
   fifo_word_t       out_word;
   logic             out_ready;
   logic [PTR_W-1:0] wr_level;
   logic [PTR_W-1:0] rd_level;

   fifo_word_t  sb_q[$];
   int          errors;
   int          acc_total;
   int          out_total;
   int          acc_at_drive;
   int          acc_target;
   int          src_mode;
   int          snk_mode;
   int          cycles;
   int          wait_cnt;
   logic [31:0] rng_state;
   logic        bp_pending;
   fifo_word_t  bp_word;

   afifo_bridge dut0 (
      .wclk      (wclk),
      .rclk      (rclk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_word   (in_word),
      .in_ready  (in_ready),
      .out_valid (out_valid),
      .out_word  (out_word),
      .out_ready (out_ready),
      .wr_level  (wr_level),
      .rd_level  (rd_level)
   );

   // 100 ns write clock
   initial begin
      wclk = 1'b0;
      forever #50 wclk = ~wclk;
   end

   // 130 ns read clock, offset so no edge meets a wclk edge
   initial begin
      rclk = 1'b0;
      #17;
      forever #65 rclk = ~rclk;
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
   endtask

   task automatic report_over_limit(input string name, input int limit, input int act);
      errors++;
      $display("CHECK FAILED at %0t ns: %s limit %0d, got %0d", $time, name, limit, act);
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("error at %0t ns: %s", $time, msg);
   endtask

   task automatic finish_run();
      $display("run complete: %0d words in, %0d words out, %0d errors",
               acc_total, out_total, errors);
      if (errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   endtask

   // source, holds a word until it is taken
   always @(negedge wclk) begin : drive_source
      logic [31:0] rnd;
      rnd = next_rand();
      if (rst !== 1'b0) begin
         in_valid = 1'b0;
         in_word  = '0;
      end else if (in_valid && acc_total == acc_at_drive) begin
         in_valid = 1'b1;
      end else if (src_mode != SRC_IDLE && acc_total < acc_target &&
                   (src_mode == SRC_FILL || rnd[1:0] != 2'b00)) begin
         in_valid      = 1'b1;
         in_word.data  = rnd[20:5];
         in_word.last  = rnd[4];
         acc_at_drive  = acc_total;
      end else begin
         in_valid = 1'b0;
      end
   end

   // sink
   always @(negedge rclk) begin : drive_sink
      logic [31:0] rnd;
      rnd = next_rand();
      if (rst !== 1'b0) begin
         out_ready = 1'b0;
      end else if (snk_mode == SNK_LOW) begin
         out_ready = 1'b0;
      end else if (snk_mode == SNK_HIGH) begin
         out_ready = 1'b1;
      end else begin
         out_ready = rnd[3];
      end
   end

   // scoreboard fill on every accepted word
   always @(posedge wclk) begin
      if (rst === 1'b0 && in_valid && in_ready) begin
         sb_q.push_back(in_word);
         acc_total++;
      end
   end

   // in-order integrity
   always @(posedge rclk) begin : check_output
      fifo_word_t exp;
      if (rst === 1'b0 && out_valid && out_ready) begin
         assert (sb_q.size() != 0)
            else report_problem("a word came out with none waiting in the scoreboard");
         if (sb_q.size() != 0) begin
            exp = sb_q.pop_front();
            out_total++;
            assert (out_word == exp) else report_mismatch("out_word", exp, out_word);
         end
      end
   end

   // stalled output must hold
   always @(posedge rclk) begin : check_hold
      if (rst !== 1'b0) begin
         bp_pending = 1'b0;
      end else begin
         if (bp_pending) begin
            assert (out_valid === 1'b1) else report_mismatch("out_valid", 1, out_valid);
            assert (out_word == bp_word) else report_mismatch("out_word", bp_word, out_word);
         end
         bp_pending = out_valid && !out_ready;
         bp_word    = out_word;
      end
   end

   always @(posedge wclk) begin
      if (rst === 1'b0) begin
         assert (wr_level <= DEPTH) else report_over_limit("wr_level", DEPTH, wr_level);
      end
   end

   always @(posedge rclk) begin
      if (rst === 1'b0) begin
         assert (rd_level <= DEPTH) else report_over_limit("rd_level", DEPTH, rd_level);
      end
   end

   // run limit
   always @(posedge wclk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         report_problem("timeout, the run did not finish within the cycle limit");
         finish_run();
      end
   end

   initial begin
      rst          = 1'b1;
      in_valid     = 1'b0;
      in_word      = '0;
      out_ready    = 1'b0;
      errors       = 0;
      acc_total    = 0;
      out_total    = 0;
      acc_at_drive = 0;
      acc_target   = 0;
      cycles       = 0;
      wait_cnt     = 0;
      rng_state    = 32'd8;
      src_mode     = SRC_IDLE;
      snk_mode     = SNK_LOW;
      bp_pending   = 1'b0;
      bp_word      = '0;

      repeat (16) @(posedge wclk);
      @(negedge wclk);
      // port closed and output empty while reset is held
      assert (in_ready === 1'b0) else report_mismatch("in_ready", 0, in_ready);
      assert (out_valid === 1'b0) else report_mismatch("out_valid", 0, out_valid);
      rst = 1'b0;

      // state right after reset
      repeat (2) @(posedge wclk);
      @(negedge wclk);
      assert (out_valid === 1'b0) else report_mismatch("out_valid", 0, out_valid);
      assert (rd_level === '0) else report_mismatch("rd_level", 0, rd_level);
      assert (in_ready === 1'b1) else report_mismatch("in_ready", 1, in_ready);

      // fill with the sink stalled
      @(posedge wclk);
      acc_target = N_TOTAL;
      src_mode   = SRC_FILL;
      while (in_ready !== 1'b0) @(negedge wclk);
      repeat (8) @(negedge wclk);
      assert (in_ready === 1'b0)
         else report_problem("in_ready rose again while the sink was stalled");
      assert (acc_total == N_FILL) else report_mismatch("accepted words", N_FILL, acc_total);
      assert (wr_level == DEPTH) else report_mismatch("wr_level", DEPTH, wr_level);
      assert (rd_level == DEPTH) else report_mismatch("rd_level", DEPTH, rd_level);

      // random traffic on both ports
      @(posedge wclk);
      src_mode = SRC_RANDOM;
      snk_mode = SNK_RANDOM;
      while (acc_total < N_TOTAL) @(negedge wclk);

      // drain with the sink always ready
      @(posedge wclk);
      src_mode = SRC_IDLE;
      snk_mode = SNK_HIGH;
      while ((sb_q.size() != 0 || out_valid) && wait_cnt < DRAIN_CYCLES) begin
         @(negedge wclk);
         wait_cnt++;
      end
      assert (sb_q.size() == 0) else report_problem("words were left in the scoreboard");

      // write side sees the last reads a few cycles later
      wait_cnt = 0;
      while (wr_level != '0 && wait_cnt < 8) begin
         @(negedge wclk);
         wait_cnt++;
      end
      assert (wr_level == '0) else report_problem("wr_level did not return to zero after the drain");
      finish_run();
   end

endmodule

// ==== src/afifo_bridge.sv ====
`timescale 1ns/1ps

module afifo_bridge
   import afifo_pkg::*;
(
   input  logic             wclk,
   input  logic             rclk,
   input  logic             rst,

   // input stream, wclk domain
   input  logic             in_valid,
   input  fifo_word_t       in_word,
   output logic             in_ready,

   // output stream, rclk domain
   output logic             out_valid,
   output fifo_word_t       out_word,
   input  logic             out_ready,

   // fill levels seen from each side
   output logic [PTR_W-1:0] wr_level,
   output logic [PTR_W-1:0] rd_level
);

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   fifo_word_t        wr_word;
   logic [PTR_W-1:0]  wr_ptr_gray;

   logic              rd_en;
   logic [ADDR_W-1:0] rd_addr;
   fifo_word_t        rd_word;
   logic [PTR_W-1:0]  rd_ptr_gray;

   afifo_wr_stage u_wr_stage (
      .wclk        (wclk),
      .rst         (rst),
      .in_valid    (in_valid),
      .in_word     (in_word),
      .in_ready    (in_ready),
      .rd_ptr_gray (rd_ptr_gray),
      .wr_en       (wr_en),
      .wr_addr     (wr_addr),
      .wr_word     (wr_word),
      .wr_ptr_gray (wr_ptr_gray),
      .wr_level    (wr_level)
   );

   dual_clock_ram u_ram (
      .wclk    (wclk),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_word (wr_word),
      .rclk    (rclk),
      .rd_en   (rd_en),
      .rd_addr (rd_addr),
      .rd_word (rd_word)
   );

   afifo_rd_stage u_rd_stage (
      .rclk        (rclk),
      .rst         (rst),
      .wr_ptr_gray (wr_ptr_gray),
      .rd_word     (rd_word),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .rd_ptr_gray (rd_ptr_gray),
      .rd_level    (rd_level),
      .out_valid   (out_valid),
      .out_word    (out_word),
      .out_ready   (out_ready)
   );

endmodule

// ==== src/afifo_pkg.sv ====
package afifo_pkg;

   // data field width of one stream word
   localparam int DATA_W = 16;

   // memory address width and entry count
   localparam int ADDR_W = 4;
   localparam int DEPTH  = 1 << ADDR_W;

   // one extra bit tells a full FIFO from an empty one
   localparam int PTR_W = ADDR_W + 1;

   // unit stored in the memory and carried on both ports
   typedef struct packed {
      logic [DATA_W-1:0] data;
      logic              last;
   } fifo_word_t;

   // what the read-side output register holds
   typedef enum logic [1:0] {
      rd_empty   = 2'd0,
      rd_loading = 2'd1,
      rd_valid   = 2'd2
   } rd_state_t;

   // gray to binary, msb first
   function automatic logic [PTR_W-1:0] gray2bin(input logic [PTR_W-1:0] gray);
      logic [PTR_W-1:0] bin;
      bin[PTR_W-1] = gray[PTR_W-1];
      for (int i = PTR_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

// ==== src/afifo_rd_stage.sv ====
`timescale 1ns/1ps

module afifo_rd_stage
   import afifo_pkg::*;
(
   input  logic              rclk,
   input  logic              rst,

   // write pointer from the wclk domain
   input  logic [PTR_W-1:0]  wr_ptr_gray,

   // memory read port
   input  fifo_word_t        rd_word,
   output logic              rd_en,
   output logic [ADDR_W-1:0] rd_addr,

   // to the write stage
   output logic [PTR_W-1:0]  rd_ptr_gray,
   output logic [PTR_W-1:0]  rd_level,

   // stream output
   output logic              out_valid,
   output fifo_word_t        out_word,
   input  logic              out_ready
);

   logic [PTR_W-1:0] rd_ptr_bin;
   logic [PTR_W-1:0] wr_gray_meta;
   logic [PTR_W-1:0] wr_gray_sync;
   logic [PTR_W-1:0] wr_ptr_sync_bin;
   logic             empty;
   rd_state_t        state;
   // rd_word holds a fetched word not yet in out_word
   logic             pre_valid;
   logic             load;

   // two-flop synchronizer for the write pointer
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         wr_gray_meta <= '0;
         wr_gray_sync <= '0;
      end else begin
         wr_gray_meta <= wr_ptr_gray;
         wr_gray_sync <= wr_gray_meta;
      end
   end

   // stale write pointer can only understate the fill
   assign wr_ptr_sync_bin = gray2bin(wr_gray_sync);
   assign rd_level        = wr_ptr_sync_bin - rd_ptr_bin;
   assign empty           = (rd_level == '0);
   assign rd_addr         = rd_ptr_bin[ADDR_W-1:0];

   // fetch decision
   always_comb begin
      case (state)
         rd_empty:   rd_en = ~empty;
         rd_loading: rd_en = ~empty;
         rd_valid:   rd_en = ~empty & (~pre_valid | out_ready);
         default:    rd_en = 1'b0;
      endcase
   end

   // output FSM and prefetch flag
   always_ff @(posedge rclk or posedge rst) begin
      if (rst) begin
         state     <= rd_empty;
         pre_valid <= 1'b0;
      end else begin
         case (state)
            rd_empty: begin
               if (rd_en) begin
                  state <= rd_loading;
               end
            end
            rd_loading: begin
               state     <= rd_valid;
               pre_valid <= rd_en;
            end
            rd_valid: begin
               if (out_ready) begin
                  if (pre_valid) begin
                     // prefetched word moves up, refill behind it
                     pre_valid <= rd_en;
                  end else if (rd_en) begin
                     state <= rd_loading;
                  end else begin
                     state <= rd_empty;
                  end
               end else if (rd_en) begin
                  pre_valid <= 1'b1;
               end
            end
            default: begin
               state     <= rd_empty;
               pre_valid <= 1'b0;
            end
         endcase
      end
   end

   // output register, loads only when free or being taken
   assign load = (state == rd_loading) | ((state == rd_valid) & out_ready & pre_valid);

   always_ff @(posedge rclk) begin
      if (load) begin
         out_word <= rd_word;
      end
   end

   assign out_valid = (state == rd_valid);

   gray_ptr #(
      .WIDTH    (PTR_W)
   ) u_rd_ptr (
      .wclk     (rclk),
      .rst      (rst),
      .inc      (rd_en),
      .ptr_bin  (rd_ptr_bin),
      .ptr_gray (rd_ptr_gray)
   );

endmodule

// ==== src/afifo_wr_stage.sv ====
`timescale 1ns/1ps

module afifo_wr_stage
   import afifo_pkg::*;
(
   input  logic              wclk,
   input  logic              rst,

   // stream input
   input  logic              in_valid,
   input  fifo_word_t        in_word,
   output logic              in_ready,

   // read pointer from the rclk domain
   input  logic [PTR_W-1:0]  rd_ptr_gray,

   // to memory and read stage
   output logic              wr_en,
   output logic [ADDR_W-1:0] wr_addr,
   output fifo_word_t        wr_word,
   output logic [PTR_W-1:0]  wr_ptr_gray,
   output logic [PTR_W-1:0]  wr_level
);

   logic [PTR_W-1:0] wr_ptr_bin;
   logic [PTR_W-1:0] rd_gray_meta;
   logic [PTR_W-1:0] rd_gray_sync;
   logic [PTR_W-1:0] rd_ptr_sync_bin;
   logic             wr_armed;
   logic             full;

   // two-flop synchronizer for the read pointer
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         rd_gray_meta <= '0;
         rd_gray_sync <= '0;
      end else begin
         rd_gray_meta <= rd_ptr_gray;
         rd_gray_sync <= rd_gray_meta;
      end
   end

   // keeps the port closed until the first edge after reset
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         wr_armed <= 1'b0;
      end else begin
         wr_armed <= 1'b1;
      end
   end

   // stale read pointer can only overstate the fill
   assign rd_ptr_sync_bin = gray2bin(rd_gray_sync);
   assign wr_level        = wr_ptr_bin - rd_ptr_sync_bin;
   assign full            = (wr_level == PTR_W'(DEPTH));

   assign in_ready = wr_armed & ~full;
   assign wr_en    = in_valid & in_ready;
   assign wr_addr  = wr_ptr_bin[ADDR_W-1:0];
   assign wr_word  = in_word;

   gray_ptr #(
      .WIDTH    (PTR_W)
   ) u_wr_ptr (
      .wclk     (wclk),
      .rst      (rst),
      .inc      (wr_en),
      .ptr_bin  (wr_ptr_bin),
      .ptr_gray (wr_ptr_gray)
   );

endmodule

// ==== src/dual_clock_ram.sv ====
`timescale 1ns/1ps

module dual_clock_ram
   import afifo_pkg::*;
(
   // write port, wclk domain
   input  logic              wclk,
   input  logic              wr_en,
   input  logic [ADDR_W-1:0] wr_addr,
   input  fifo_word_t        wr_word,

   // read port, rclk domain
   input  logic              rclk,
   input  logic              rd_en,
   input  logic [ADDR_W-1:0] rd_addr,
   output fifo_word_t        rd_word
);

   fifo_word_t mem [DEPTH];

   // write side
   always_ff @(posedge wclk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_word;
      end
   end

   // registered read, holds between fetches
   always_ff @(posedge rclk) begin
      if (rd_en) begin
         rd_word <= mem[rd_addr];
      end
   end

endmodule

// ==== src/gray_ptr.sv ====
`timescale 1ns/1ps

module gray_ptr
   import afifo_pkg::*;
#(
   parameter int WIDTH = PTR_W
) (
   input  logic             wclk,
   input  logic             rst,
   input  logic             inc,
   output logic [WIDTH-1:0] ptr_bin,
   output logic [WIDTH-1:0] ptr_gray
);

   logic [WIDTH-1:0] bin_next;
   logic [WIDTH-1:0] gray_next;

   // next count and its gray code
   assign bin_next  = ptr_bin + WIDTH'(1);
   assign gray_next = bin_next ^ (bin_next >> 1);

   // binary count for local addressing and arithmetic
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         ptr_bin <= '0;
      end else if (inc) begin
         ptr_bin <= bin_next;
      end
   end

   // gray code kept in its own flops so that it
   // leaves the domain straight from a register
   always_ff @(posedge wclk or posedge rst) begin
      if (rst) begin
         ptr_gray <= '0;
      end else if (inc) begin
         ptr_gray <= gray_next;
      end
   end

endmodule
